// ==== hdl/mem_pkg.sv ====
package mem_pkg;

	localparam int ADDR_W       = 16;
	localparam int DATA_W       = 16;
	localparam int NUM_BANKS    = 4;
	localparam int MEM_READ_LAT = 2;                        // Cycles from rd to mem_rdata
	localparam int BANK_W       = $clog2(NUM_BANKS);
	localparam int ROW_W        = ADDR_W - BANK_W - 1;      // Byte bit and bank bits dropped
	localparam int BANK_ROWS    = 1 << ROW_W;

	typedef logic [ADDR_W-1:0] addr_t;                      // Byte address
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [BANK_W-1:0] bank_t;                      // Address bits 2:1
	typedef logic [ROW_W-1:0]  row_t;                       // Address bits 15:3

	// Banks take one request per cycle and never refuse
	typedef struct packed {
		addr_t addr;
		data_t wdata;
		logic  wr;
		logic  rd;
	} mem_req_t;

endpackage

// ==== hdl/cache_pkg.sv ====
package cache_pkg;
	import mem_pkg::*;

	localparam int TAG_W      = 5;
	localparam int INDEX_W    = 8;
	localparam int OFFSET_W   = 3;
	localparam int NUM_LINES  = 1 << INDEX_W;
	localparam int LINE_WORDS = 4;

	typedef logic [TAG_W-1:0]              tag_t;
	typedef logic [INDEX_W-1:0]            index_t;
	typedef logic [OFFSET_W-1:0]           offset_t;       // Byte offset in line
	typedef logic [$clog2(LINE_WORDS)-1:0] word_t;         // Word slot in line

	typedef struct packed {
		logic    enable;
		logic    comp;                                      // Compare mode checks the tag
		logic    write;
		tag_t    tag;
		index_t  index;
		offset_t offset;
		data_t   wdata;
	} cache_acc_t;

	typedef enum logic [3:0] {
		IDLE,
		COMPARE,
		WB_0,
		WB_1,
		WB_2,
		WB_3,
		REQ_0,
		REQ_1,
		FILL_0,
		FILL_1,
		FILL_2,
		FILL_3,
		DONE
	} ctrl_state_t;

endpackage

// ==== hdl/banked_mem.sv ====
`timescale 1ns/1ps

module banked_mem
	import mem_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  mem_req_t mem_req,
	output data_t    mem_rdata
);

	bank_t req_bank;
	row_t  req_row;
	bank_t sel_q;                                           // Bank of the read in stage 1
	data_t bank_q    [NUM_BANKS];
	data_t data_pipe [MEM_READ_LAT-1];

	logic [MEM_READ_LAT-1:0] rd_vld_q;

	assign req_bank = mem_req.addr[BANK_W:1];
	assign req_row  = mem_req.addr[ADDR_W-1:BANK_W+1];

	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
		data_t mem [BANK_ROWS] = '{default: '0};            // Every bank starts at zero

		always_ff @(posedge clk) begin
			if (mem_req.wr && (req_bank == b))
				mem[req_row] <= mem_req.wdata;              // Write takes effect at once
			if (mem_req.rd && (req_bank == b))
				bank_q[b] <= mem[req_row];
		end
	end

	always_ff @(posedge clk) begin
		sel_q        <= req_bank;
		data_pipe[0] <= bank_q[sel_q];
		for (int s = 1; s < MEM_READ_LAT - 1; s++)
			data_pipe[s] <= data_pipe[s-1];
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			rd_vld_q <= '0;
		else
			rd_vld_q <= {rd_vld_q[MEM_READ_LAT-2:0], mem_req.rd};
	end

	assign mem_rdata = rd_vld_q[MEM_READ_LAT-1] ? data_pipe[MEM_READ_LAT-2] : '0;

	a_no_rd_wr: assert property (@(posedge clk) disable iff (!rst_n)
		!(mem_req.rd && mem_req.wr));

endmodule

// ==== hdl/cache_array.sv ====
`timescale 1ns/1ps

module cache_array
	import mem_pkg::*;
	import cache_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  cache_acc_t cache_acc,
	output logic       tag_match,
	output logic       valid,
	output logic       dirty,
	output tag_t       victim_tag,
	output data_t      rdata
);

	tag_t  tag_mem  [NUM_LINES];
	data_t data_mem [NUM_LINES][LINE_WORDS];

	logic [NUM_LINES-1:0] valid_q;
	logic [NUM_LINES-1:0] dirty_q;

	index_t idx;
	word_t  word;
	logic   wr_en;

	assign idx   = cache_acc.index;
	assign word  = cache_acc.offset[OFFSET_W-1:1];         // Bit 0 ignored for word access
	assign wr_en = cache_acc.enable && cache_acc.write;

	// Lookup is combinational
	assign victim_tag = tag_mem[idx];
	assign tag_match  = (tag_mem[idx] == cache_acc.tag);
	assign valid      = valid_q[idx];
	assign dirty      = dirty_q[idx];
	assign rdata      = data_mem[idx][word];

	always_ff @(posedge clk) begin
		if (wr_en)
			data_mem[idx][word] <= cache_acc.wdata;
	end

	always_ff @(posedge clk) begin
		if (wr_en && !cache_acc.comp)
			tag_mem[idx] <= cache_acc.tag;                  // Fill installs new tag
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else if (wr_en) begin
			if (cache_acc.comp) begin
				dirty_q[idx] <= 1'b1;
			end else begin
				valid_q[idx] <= 1'b1;
				dirty_q[idx] <= 1'b0;
			end
		end
	end

	// A compare write only follows a hit
	a_comp_write_hit: assert property (@(posedge clk) disable iff (!rst_n)
		(wr_en && cache_acc.comp) |-> (valid && tag_match));

endmodule

// ==== hdl/cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl
	import mem_pkg::*;
	import cache_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  addr_t      addr,
	input  data_t      wdata,
	input  logic       rd,
	input  logic       wr,
	input  logic       tag_match,
	input  logic       valid,
	input  logic       dirty,
	input  tag_t       victim_tag,
	input  data_t      mem_rdata,
	output cache_acc_t cache_acc,
	output mem_req_t   mem_req,
	output logic       done,
	output logic       stall,
	output logic       cache_hit,
	output logic       err
);

	function automatic offset_t word_offset(word_t w);
		return {w, 1'b0};
	endfunction

	ctrl_state_t state;
	ctrl_state_t next_state;
	addr_t       req_addr;
	data_t       req_wdata;
	logic        req_wr;
	tag_t        req_tag;
	index_t      req_index;
	offset_t     req_offset;
	logic        accept;
	logic        hit;
	logic        mem_rd;
	logic        mem_wr;
	offset_t     mem_off;

	logic [MEM_READ_LAT-1:0] fill_vld_q;                    // Reads in flight
	offset_t                 fill_off_q [MEM_READ_LAT];

	assign {req_tag, req_index, req_offset} = req_addr;
	assign accept = (state == IDLE) && (rd ^ wr);          // Both set is refused
	assign hit    = tag_match && valid;

	assign stall     = (state != IDLE);
	assign cache_hit = (state == COMPARE) && hit;
	assign done      = cache_hit || (state == DONE);

	always_ff @(posedge clk) begin
		if (accept) begin
			req_addr  <= addr;
			req_wdata <= wdata;
			req_wr    <= wr;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
			err   <= 1'b0;
		end else begin
			state <= next_state;
			err   <= (state == IDLE) && rd && wr;
		end
	end

	// Fill words come back MEM_READ_LAT cycles after their request
	always_ff @(posedge clk) begin
		if (!rst_n)
			fill_vld_q <= '0;
		else
			fill_vld_q <= {fill_vld_q[MEM_READ_LAT-2:0], mem_rd};
	end

	always_ff @(posedge clk) begin
		fill_off_q[0] <= mem_off;
		for (int i = 1; i < MEM_READ_LAT; i++)
			fill_off_q[i] <= fill_off_q[i-1];
	end

	always_comb begin
		next_state = state;
		mem_wr     = 1'b0;
		cache_acc  = '{enable: 1'b0, comp: 1'b0, write: 1'b0, tag: req_tag,
			index: req_index, offset: req_offset, wdata: req_wdata};

		case (state)
			IDLE:    if (accept) next_state = COMPARE;
			COMPARE: begin
				cache_acc.enable = 1'b1;
				cache_acc.comp   = 1'b1;
				cache_acc.write  = req_wr && hit;             // Write hit lands here
				if (hit)
					next_state = IDLE;
				else if (valid && dirty)
					next_state = WB_0;
				else
					next_state = REQ_0;
			end
			WB_0:    next_state = WB_1;
			WB_1:    next_state = WB_2;
			WB_2:    next_state = WB_3;
			WB_3:    next_state = REQ_0;
			REQ_0:   next_state = REQ_1;
			REQ_1:   next_state = FILL_0;
			FILL_0:  next_state = FILL_1;
			FILL_1:  next_state = FILL_2;
			FILL_2:  next_state = FILL_3;
			FILL_3:  next_state = DONE;
			DONE:    begin
				cache_acc.enable = 1'b1;
				cache_acc.comp   = 1'b1;
				cache_acc.write  = req_wr;                    // Merge CPU word after fill
				next_state       = IDLE;
			end
			default: next_state = IDLE;
		endcase

		// Write-back and fill requests step through the same words
		case (state)
			WB_0, REQ_0:  mem_off = word_offset(2'd0);
			WB_1, REQ_1:  mem_off = word_offset(2'd1);
			WB_2, FILL_0: mem_off = word_offset(2'd2);
			WB_3, FILL_1: mem_off = word_offset(2'd3);
			default:      mem_off = '0;
		endcase
		mem_rd = state inside {REQ_0, REQ_1, FILL_0, FILL_1};

		// Victim words stream out of the array
		if (state inside {WB_0, WB_1, WB_2, WB_3}) begin
			mem_wr           = 1'b1;
			cache_acc.enable = 1'b1;
			cache_acc.offset = mem_off;
		end

		if (state inside {FILL_0, FILL_1, FILL_2, FILL_3}) begin
			cache_acc.enable = 1'b1;
			cache_acc.write  = fill_vld_q[MEM_READ_LAT-1];
			cache_acc.offset = fill_off_q[MEM_READ_LAT-1];
			cache_acc.wdata  = mem_rdata;                    // Fill word from memory
		end

		mem_req.addr  = {(mem_wr ? victim_tag : req_tag), req_index, mem_off};
		mem_req.wdata = '0;                                 // Array supplies it at top
		mem_req.wr    = mem_wr;
		mem_req.rd    = mem_rd;
	end

	// Every done cycle hands the controller back to idle
	a_done_in_stall: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> stall ##1 !stall);

	a_hit_with_done: assert property (@(posedge clk) disable iff (!rst_n)
		cache_hit |-> done && $past(accept));

endmodule

// ==== hdl/mem_system.sv ====
`timescale 1ns/1ps

module mem_system
	import mem_pkg::*;
	import cache_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  addr_t addr,
	input  data_t wdata,
	input  logic  rd,
	input  logic  wr,
	output data_t rdata,
	output logic  done,
	output logic  stall,
	output logic  cache_hit,
	output logic  err
);

	cache_acc_t cache_acc;
	mem_req_t   ctrl_mem_req;
	mem_req_t   mem_req;
	logic       tag_match;
	logic       line_valid;
	logic       line_dirty;
	tag_t       victim_tag;
	data_t      mem_rdata;

	// Write-back word is the array read port
	assign mem_req = '{addr: ctrl_mem_req.addr, wdata: rdata,
		wr: ctrl_mem_req.wr, rd: ctrl_mem_req.rd};

	cache_ctrl u_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.addr       (addr),
		.wdata      (wdata),
		.rd         (rd),
		.wr         (wr),
		.tag_match  (tag_match),
		.valid      (line_valid),
		.dirty      (line_dirty),
		.victim_tag (victim_tag),
		.mem_rdata  (mem_rdata),
		.cache_acc  (cache_acc),
		.mem_req    (ctrl_mem_req),
		.done       (done),
		.stall      (stall),
		.cache_hit  (cache_hit),
		.err        (err)
	);

	cache_array u_cache (
		.clk        (clk),
		.rst_n      (rst_n),
		.cache_acc  (cache_acc),
		.tag_match  (tag_match),
		.valid      (line_valid),
		.dirty      (line_dirty),
		.victim_tag (victim_tag),
		.rdata      (rdata)
	);

	banked_mem u_mem (
		.clk       (clk),
		.rst_n     (rst_n),
		.mem_req   (mem_req),
		.mem_rdata (mem_rdata)
	);

endmodule

// ==== tb/mem_system_tb.sv ====
`timescale 1ns/1ps

module mem_system_tb
	import mem_pkg::*;
	import cache_pkg::*;
();

	localparam int NUM_RAND  = 190;
	localparam int MAX_LAT   = 14;                           // Dirty miss plus slack
	localparam int CYC_LIMIT = 200 * MAX_LAT + 100;

	logic  clk = 1'b0;
	logic  rst_n;
	addr_t addr;
	data_t wdata;
	logic  rd;
	logic  wr;
	data_t rdata;
	logic  done;
	logic  stall;
	logic  cache_hit;
	logic  err;

	data_t word_map [addr_t];                                // Keyed by word aligned address
	tag_t  line_tag   [NUM_LINES];
	logic  line_valid [NUM_LINES];
	logic  line_dirty [NUM_LINES];

	logic        busy     = 1'b0;                            // Accepted request in flight
	int          cyc      = 0;                               // Cycle count from acceptance
	int          exp_lat  = 0;
	logic        exp_hit  = 1'b0;
	logic        exp_rd   = 1'b0;
	data_t       exp_data = '0;
	logic        exp_err  = 1'b0;
	int          errors   = 0;
	int          cycles   = 0;
	int          requests = 0;
	int          tests    = 0;
	int          req_mark = 0;
	int          err_mark = 0;
	logic [31:0] seed     = 32'd39372;

	mem_system u_mem_system (
		.clk       (clk),
		.rst_n     (rst_n),
		.addr      (addr),
		.wdata     (wdata),
		.rd        (rd),
		.wr        (wr),
		.rdata     (rdata),
		.done      (done),
		.stall     (stall),
		.cache_hit (cache_hit),
		.err       (err)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYC_LIMIT) begin
			$display("Timeout, run stopped after %0d cycles", cycles);
			$display("Errors found");
			$finish;
		end
	end

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed ^ (seed >> 16);                          // Fold high bits down
	endfunction

	function automatic addr_t make_addr(tag_t tag, index_t idx, offset_t off);
		return {tag, idx, off};
	endfunction

	task automatic report_mismatch(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		errors++;
		$display("[FAIL] %0d ns %s expected %h got %h", $time, name, expected, actual);
	endtask

	task automatic clear_inputs();
		addr  = '0;
		wdata = '0;
		rd    = 1'b0;
		wr    = 1'b0;
	endtask

	// Noise on the inputs while the controller is busy
	task automatic drive_junk();
		logic [31:0] r;
		r     = next_rand();
		addr  = r[15:0];
		wdata = r[31:16];
		rd    = r[20];
		wr    = r[9];
	endtask

	task automatic run_access(input addr_t a, input data_t d, input logic is_wr);
		addr_t  wa;
		tag_t   tag;
		index_t idx;
		logic   hit;
		wa         = {a[15:1], 1'b0};
		{tag, idx} = a[15:3];
		hit        = line_valid[idx] && (line_tag[idx] == tag);
		exp_hit    = hit;
		exp_lat    = hit ? 1 : ((line_valid[idx] && line_dirty[idx]) ? 12 : 8);
		exp_rd     = !is_wr;
		exp_data   = word_map.exists(wa) ? word_map[wa] : '0;
		addr       = a;
		wdata      = d;
		rd         = !is_wr;
		wr         = is_wr;
		@(posedge clk);                                      // Accepting edge
		@(negedge clk);
		busy = 1'b1;
		cyc  = 1;
		while (!done) begin
			drive_junk();
			@(negedge clk);
			cyc++;
		end
		drive_junk();
		@(negedge clk);
		busy = 1'b0;
		clear_inputs();
		if (!hit) begin
			line_valid[idx] = 1'b1;
			line_tag[idx]   = tag;
			line_dirty[idx] = 1'b0;
		end
		if (is_wr) begin
			word_map[wa]    = d;
			line_dirty[idx] = 1'b1;
		end
		requests++;
	endtask

	task automatic run_bad(input addr_t a, input data_t d);
		addr  = a;
		wdata = d;
		rd    = 1'b1;
		wr    = 1'b1;
		@(posedge clk);
		@(negedge clk);
		exp_err = 1'b1;                                      // Pulse due in this cycle
		clear_inputs();
		@(negedge clk);
		exp_err = 1'b0;
		requests++;
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("Test %0d %s: %0d requests, %0d errors", tests, name,
			requests - req_mark, errors - err_mark);
		req_mark = requests;
		err_mark = errors;
	endtask

	a_stall: assert property (@(posedge clk) disable iff (!rst_n) stall == busy)
		else report_mismatch("stall", busy, $sampled(stall));

	a_done: assert property (@(posedge clk) disable iff (!rst_n)
		done == (busy && cyc == exp_lat))
		else report_mismatch("done", busy && cyc == exp_lat, $sampled(done));

	a_hit: assert property (@(posedge clk) disable iff (!rst_n)
		cache_hit == (busy && exp_hit && cyc == 1))
		else report_mismatch("cache_hit", busy && exp_hit && cyc == 1, $sampled(cache_hit));

	a_err: assert property (@(posedge clk) disable iff (!rst_n) err == exp_err)
		else report_mismatch("err", exp_err, $sampled(err));

	a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
		(busy && exp_rd && cyc == exp_lat) |-> (rdata == exp_data))
		else report_mismatch("rdata", exp_data, $sampled(rdata));

	initial begin
		logic [31:0] r;
		logic [31:0] dir;
		for (int i = 0; i < NUM_LINES; i++) begin
			line_valid[i] = 1'b0;
			line_dirty[i] = 1'b0;
			line_tag[i]   = '0;
		end
		clear_inputs();
		rst_n = 1'b0;
		repeat (10) @(negedge clk);
		rst_n = 1'b1;

		repeat (5) @(negedge clk);                           // Outputs must stay quiet
		end_test("idle after reset");

		run_access(make_addr(5'd1, 8'd5, 3'd2), 16'ha5a5, 1'b1);  // Clean miss
		run_access(make_addr(5'd1, 8'd5, 3'd2), 16'h0000, 1'b0);
		run_access(make_addr(5'd1, 8'd5, 3'd4), 16'h0000, 1'b0);
		run_access(make_addr(5'd2, 8'd5, 3'd6), 16'h5a5a, 1'b1);  // Dirty victim
		run_access(make_addr(5'd1, 8'd5, 3'd2), 16'h0000, 1'b0);
		run_access(make_addr(5'd2, 8'd5, 3'd6), 16'h0000, 1'b0);
		end_test("eviction and refill");

		run_bad(make_addr(5'd1, 8'd5, 3'd2), 16'hdead);
		run_access(make_addr(5'd1, 8'd5, 3'd2), 16'h0000, 1'b0);
		run_bad(make_addr(5'd3, 8'd9, 3'd0), 16'hbeef);
		run_access(make_addr(5'd3, 8'd9, 3'd0), 16'h0000, 1'b0);
		end_test("refused requests");

		for (int n = 0; n < NUM_RAND; n++) begin
			r   = next_rand();
			dir = next_rand();
			if (dir[31:29] == 3'd0)
				run_bad(make_addr(r[1:0], r[8] ? 8'hff : 8'h00, r[14:12]), r[31:16]);
			else
				run_access(make_addr(r[1:0], r[8] ? 8'hff : 8'h00, r[14:12]), r[31:16],
					dir[31:29] < 3'd4);
		end
		end_test("random traffic");

		repeat (3) @(negedge clk);
		$display("Summary: %0d tests, %0d requests, %0d errors", tests, requests, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// ==== vlog.f ====
hdl/mem_pkg.sv
hdl/cache_pkg.sv
hdl/banked_mem.sv
hdl/cache_array.sv
hdl/cache_ctrl.sv
hdl/mem_system.sv
tb/mem_system_tb.sv
